/* common/fcp_pkg.sv */
// Shared types and sizes for the FCP frame switch, imported by every switch module

package fcp_pkg;

	// --------------------
	// Sizing
	// --------------------

	// Port address space and the mapped channel window inside it
	localparam int FCP_NUM_PORTS  = 16;
	localparam int FCP_FIRST_CHAN = 1;
	localparam int FCP_NUM_CHAN   = 6;

	// Channel FIFO size in bytes
	localparam int FCP_FIFO_DEPTH = 16;
	localparam int FCP_FIFO_AW    = 4;

	// --------------------
	// Stream types
	// --------------------

	// One byte of a frame with its framing flags
	typedef struct packed
	{
		logic       sof;
		logic       eof;
		logic [7:0] data;
	} fcp_beat_t;

	// Platform port address
	typedef logic [3:0] fcp_port_t;

	// One bit per port address
	typedef logic [FCP_NUM_PORTS-1:0] fcp_en_t;

	// --------------------
	// FSM states
	// --------------------

	// Write side, IN_DROP swallows a frame to an unmapped port
	typedef enum logic [1:0]
	{
		IN_IDLE  = 2'd0,
		IN_FRAME = 2'd1,
		IN_DROP  = 2'd2
	} ingress_state_e;

	// Read side
	typedef enum logic
	{
		EG_IDLE  = 1'b0,
		EG_FRAME = 1'b1
	} egress_state_e;

endpackage

/* fcp_channel_if/fcp_channel_if.sv */
// Channel interface: decodes the locked write and read ports and steers streams to the FIFOs
`timescale 1ns/1ns

module fcp_channel_if
	import fcp_pkg::*;
(
	// Write side from ingress
	input  fcp_beat_t                wr_beat_i,
	input  logic                     wr_valid_i,
	output logic                     wr_ready_o,
	input  fcp_port_t                wr_port_i,
	input  logic                     wr_lock_i,
	// Toward the channel FIFOs
	output fcp_beat_t                ch_wr_beat_o,
	output logic [FCP_NUM_CHAN-1:0]  ch_wr_valid_o,
	input  logic [FCP_NUM_CHAN-1:0]  ch_wr_ready_i,
	// From the channel FIFOs
	input  fcp_beat_t                ch_rd_beat_i [FCP_NUM_CHAN],
	input  logic [FCP_NUM_CHAN-1:0]  ch_rd_valid_i,
	output logic [FCP_NUM_CHAN-1:0]  ch_rd_ready_o,
	// Read side toward egress
	input  fcp_port_t                rd_port_i,
	input  logic                     rd_lock_i,
	output fcp_beat_t                rd_beat_o,
	output logic                     rd_valid_o,
	input  logic                     rd_ready_i,
	// Enables for user logic
	output fcp_en_t                  wenables_o,
	output fcp_en_t                  renables_o
);

	// Only ports 1 to 6 have a FIFO behind them
	logic [FCP_NUM_CHAN-1:0] wen_chan;
	logic [FCP_NUM_CHAN-1:0] ren_chan;

	// One-hot decode, all zero while the port is not locked
	function automatic fcp_en_t decode_port(input fcp_port_t port, input logic lock);
		fcp_en_t en;
		en = '0;
		if (lock)
			en[port] = 1'b1;
		return en;
	endfunction

	// --------------------
	// Enable decoders
	// --------------------

	assign wenables_o = decode_port(wr_port_i, wr_lock_i);
	assign renables_o = decode_port(rd_port_i, rd_lock_i);

	assign wen_chan = wenables_o[FCP_FIRST_CHAN +: FCP_NUM_CHAN];
	assign ren_chan = renables_o[FCP_FIRST_CHAN +: FCP_NUM_CHAN];

	// --------------------
	// Write demux
	// --------------------

	// Same beat to every FIFO, valid only to the enabled one
	assign ch_wr_beat_o  = wr_beat_i;
	assign ch_wr_valid_o = {FCP_NUM_CHAN{wr_valid_i}} & wen_chan;
	assign wr_ready_o    = |(ch_wr_ready_i & wen_chan);

	// --------------------
	// Read mux
	// --------------------

	assign ch_rd_ready_o = {FCP_NUM_CHAN{rd_ready_i}} & ren_chan;
	assign rd_valid_o    = |(ch_rd_valid_i & ren_chan);

	// AND-OR mux over the channels
	always_comb
	begin
		rd_beat_o = '0;
		for (int i = 0; i < FCP_NUM_CHAN; i++)
		begin
			if (ren_chan[i])
				rd_beat_o = rd_beat_o | ch_rd_beat_i[i];
		end
	end

endmodule

/* list.f */
common/fcp_pkg.sv
fcp_channel_if/fcp_channel_if.sv
rtl/fcp_ingress_stage.sv
rtl/fcp_chan_fifo.sv
rtl/fcp_egress_stage.sv
rtl/fcp_switch_top.sv
sim/tb_fcp_switch.sv

/* rtl/fcp_chan_fifo.sv */
// Channel byte FIFO with first-word fall-through, one per mapped port
`timescale 1ns/1ns

module fcp_chan_fifo
	import fcp_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	// Write side
	input  fcp_beat_t wr_beat_i,
	input  logic      wr_valid_i,
	output logic      wr_ready_o,
	// Read side
	output fcp_beat_t rd_beat_o,
	output logic      rd_valid_o,
	input  logic      rd_ready_i
);

	fcp_beat_t mem [FCP_FIFO_DEPTH];

	// Extra top bit tells full from empty
	logic [FCP_FIFO_AW:0] wptr_q;
	logic [FCP_FIFO_AW:0] rptr_q;
	logic                 empty;
	logic                 full;
	logic                 do_write;
	logic                 do_read;

	// --------------------
	// Status
	// --------------------

	assign empty = (wptr_q == rptr_q);
	assign full  = (wptr_q[FCP_FIFO_AW] != rptr_q[FCP_FIFO_AW]) &&
		(wptr_q[FCP_FIFO_AW-1:0] == rptr_q[FCP_FIFO_AW-1:0]);

	assign wr_ready_o = !full;
	assign rd_valid_o = !empty;

	assign do_write = wr_valid_i && !full;
	assign do_read  = rd_ready_i && !empty;

	// Head entry shows without a read request
	assign rd_beat_o = mem[rptr_q[FCP_FIFO_AW-1:0]];

	// --------------------
	// Pointers
	// --------------------

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			wptr_q <= '0;
			rptr_q <= '0;
		end
		else
		begin
			if (do_write)
				wptr_q <= wptr_q + 1'b1;
			if (do_read)
				rptr_q <= rptr_q + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk_i)
	begin
		if (do_write)
			mem[wptr_q[FCP_FIFO_AW-1:0]] <= wr_beat_i;
	end

endmodule

/* rtl/fcp_egress_stage.sv */
// Egress stage: locks the read port per frame and registers beats toward the platform
`timescale 1ns/1ns

module fcp_egress_stage
	import fcp_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	// Read port select from the platform
	input  fcp_port_t outport_addr_i,
	// Toward the channel interface
	output fcp_port_t rd_port_o,
	output logic      rd_lock_o,
	input  fcp_beat_t rd_beat_i,
	input  logic      rd_valid_i,
	output logic      rd_ready_o,
	// Platform output
	output fcp_beat_t out_beat_o,
	output logic      out_valid_o,
	input  logic      out_ready_i
);

	egress_state_e state_q;
	fcp_port_t     port_q;
	logic          busy_q;
	fcp_beat_t     out_q;
	logic          out_full_q;
	logic          rd_accept;

	assign rd_lock_o  = (state_q == EG_FRAME);
	assign rd_port_o  = port_q;

	// Take a beat when the output slot is free or draining
	assign rd_ready_o = rd_lock_o && (!out_full_q || out_ready_i);
	assign rd_accept  = rd_valid_i && rd_ready_o;

	assign out_beat_o  = out_q;
	assign out_valid_o = out_full_q;

	// --------------------
	// Control
	// --------------------

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state_q    <= EG_IDLE;
			port_q     <= '0;
			busy_q     <= 1'b0;
			out_full_q <= 1'b0;
		end
		else
		begin
			if (rd_accept)
				out_full_q <= 1'b1;
			else if (out_ready_i)
				out_full_q <= 1'b0;
			case (state_q)
				EG_IDLE:
				begin
					port_q  <= outport_addr_i;
					state_q <= EG_FRAME;
				end
				EG_FRAME:
				begin
					if (rd_accept)
					begin
						busy_q <= !rd_beat_i.eof;
						if (rd_beat_i.eof)
							state_q <= EG_IDLE;
					end
					// No frame started yet, so follow a new address
					else if (!busy_q && (outport_addr_i != port_q))
						state_q <= EG_IDLE;
				end
				default: state_q <= EG_IDLE;
			endcase
		end
	end

	// Output payload
	always_ff @(posedge clk_i)
	begin
		if (rd_accept)
			out_q <= rd_beat_i;
	end

endmodule

/* rtl/fcp_ingress_stage.sv */
// Ingress register slice: locks the write port per frame and drops frames to unmapped ports
`timescale 1ns/1ns

module fcp_ingress_stage
	import fcp_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	// Platform input
	input  fcp_beat_t in_beat_i,
	input  logic      in_valid_i,
	output logic      in_ready_o,
	input  fcp_port_t inport_addr_i,
	// Toward the channel interface
	output fcp_beat_t wr_beat_o,
	output logic      wr_valid_o,
	input  logic      wr_ready_i,
	output fcp_port_t wr_port_o,
	output logic      wr_lock_o
);

	ingress_state_e state_q;
	fcp_port_t      port_q;
	fcp_beat_t      beat_q;
	logic           full_q;
	logic           live_q;
	logic           addr_mapped;
	logic           in_accept;
	logic           out_take;
	logic           load_slice;

	assign addr_mapped = (inport_addr_i >= fcp_port_t'(FCP_FIRST_CHAN)) &&
		(inport_addr_i < fcp_port_t'(FCP_FIRST_CHAN + FCP_NUM_CHAN));

	// Holding eof blocks input until it leaves, so the lock stays put
	always_comb
	begin
		case (state_q)
			IN_IDLE:  in_ready_o = live_q;
			IN_DROP:  in_ready_o = 1'b1;
			IN_FRAME: in_ready_o = !full_q || (wr_ready_i && !beat_q.eof);
			default:  in_ready_o = 1'b0;
		endcase
	end

	assign in_accept  = in_valid_i && in_ready_o;
	assign out_take   = full_q && wr_ready_i;
	assign load_slice = in_accept && ((state_q == IN_FRAME) ||
		(state_q == IN_IDLE && in_beat_i.sof && addr_mapped));

	assign wr_beat_o  = beat_q;
	assign wr_valid_o = full_q;
	assign wr_port_o  = port_q;
	assign wr_lock_o  = (state_q == IN_FRAME);

	// --------------------
	// Control
	// --------------------

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state_q <= IN_IDLE;
			port_q  <= '0;
			full_q  <= 1'b0;
			live_q  <= 1'b0;
		end
		else
		begin
			live_q <= 1'b1;
			if (load_slice)
				full_q <= 1'b1;
			else if (out_take)
				full_q <= 1'b0;
			case (state_q)
				IN_IDLE:
				begin
					// Beats outside a frame are discarded here
					if (in_accept && in_beat_i.sof)
					begin
						if (addr_mapped)
						begin
							port_q  <= inport_addr_i;
							state_q <= IN_FRAME;
						end
						else if (!in_beat_i.eof)
							state_q <= IN_DROP;
					end
				end
				IN_DROP:
				begin
					if (in_accept && in_beat_i.eof)
						state_q <= IN_IDLE;
				end
				IN_FRAME:
				begin
					if (out_take && beat_q.eof)
						state_q <= IN_IDLE;
				end
				default: state_q <= IN_IDLE;
			endcase
		end
	end

	// Payload
	always_ff @(posedge clk_i)
	begin
		if (load_slice)
			beat_q <= in_beat_i;
	end

endmodule

/* rtl/fcp_switch_top.sv */
// FCP frame switch top level: ingress, channel interface, six channel FIFOs and egress
`timescale 1ns/1ns

module fcp_switch_top
	import fcp_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	// Platform input
	input  fcp_beat_t in_beat_i,
	input  logic      in_valid_i,
	output logic      in_ready_o,
	input  fcp_port_t inport_addr_i,
	// Platform output
	output fcp_beat_t out_beat_o,
	output logic      out_valid_o,
	input  logic      out_ready_i,
	input  fcp_port_t outport_addr_i,
	// Enables for user logic
	output fcp_en_t   wenables_o,
	output fcp_en_t   renables_o
);

	// Ingress to channel interface
	fcp_beat_t wr_beat;
	logic      wr_valid;
	logic      wr_ready;
	fcp_port_t wr_port;
	logic      wr_lock;

	// Channel interface to egress
	fcp_beat_t rd_beat;
	logic      rd_valid;
	logic      rd_ready;
	fcp_port_t rd_port;
	logic      rd_lock;

	// Per-channel FIFO links
	fcp_beat_t               ch_wr_beat;
	logic [FCP_NUM_CHAN-1:0] ch_wr_valid;
	logic [FCP_NUM_CHAN-1:0] ch_wr_ready;
	fcp_beat_t               ch_rd_beat [FCP_NUM_CHAN];
	logic [FCP_NUM_CHAN-1:0] ch_rd_valid;
	logic [FCP_NUM_CHAN-1:0] ch_rd_ready;

	fcp_ingress_stage u_ingress (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.in_beat_i     (in_beat_i),
		.in_valid_i    (in_valid_i),
		.in_ready_o    (in_ready_o),
		.inport_addr_i (inport_addr_i),
		.wr_beat_o     (wr_beat),
		.wr_valid_o    (wr_valid),
		.wr_ready_i    (wr_ready),
		.wr_port_o     (wr_port),
		.wr_lock_o     (wr_lock)
	);

	fcp_channel_if u_chan_if (
		.wr_beat_i     (wr_beat),
		.wr_valid_i    (wr_valid),
		.wr_ready_o    (wr_ready),
		.wr_port_i     (wr_port),
		.wr_lock_i     (wr_lock),
		.ch_wr_beat_o  (ch_wr_beat),
		.ch_wr_valid_o (ch_wr_valid),
		.ch_wr_ready_i (ch_wr_ready),
		.ch_rd_beat_i  (ch_rd_beat),
		.ch_rd_valid_i (ch_rd_valid),
		.ch_rd_ready_o (ch_rd_ready),
		.rd_port_i     (rd_port),
		.rd_lock_i     (rd_lock),
		.rd_beat_o     (rd_beat),
		.rd_valid_o    (rd_valid),
		.rd_ready_i    (rd_ready),
		.wenables_o    (wenables_o),
		.renables_o    (renables_o)
	);

	// Index 0 serves port FCP_FIRST_CHAN
	for (genvar i = 0; i < FCP_NUM_CHAN; i++)
	begin : g_chan
		fcp_chan_fifo u_fifo (
			.clk_i      (clk_i),
			.reset_i    (reset_i),
			.wr_beat_i  (ch_wr_beat),
			.wr_valid_i (ch_wr_valid[i]),
			.wr_ready_o (ch_wr_ready[i]),
			.rd_beat_o  (ch_rd_beat[i]),
			.rd_valid_o (ch_rd_valid[i]),
			.rd_ready_i (ch_rd_ready[i])
		);
	end

	fcp_egress_stage u_egress (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.outport_addr_i (outport_addr_i),
		.rd_port_o      (rd_port),
		.rd_lock_o      (rd_lock),
		.rd_beat_i      (rd_beat),
		.rd_valid_i     (rd_valid),
		.rd_ready_o     (rd_ready),
		.out_beat_o     (out_beat_o),
		.out_valid_o    (out_valid_o),
		.out_ready_i    (out_ready_i)
	);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the FCP switch testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_fcp_switch \
	--Mdir obj_dir -o tb_fcp_switch
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_fcp_switch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

/* sim/tb_fcp_switch.sv */
// Testbench for the FCP frame switch that sends frames to every port and checks the drained output
`timescale 1ns/1ns

module tb_fcp_switch
	import fcp_pkg::*;
();

	localparam logic [31:0] SEED = 32'h3b1f;

	// Cycle limits for the wait loops
	localparam int IN_LIMIT    = 200;
	localparam int DRAIN_LIMIT = 600;
	localparam int STALL_LIMIT = 300;
	localparam int STALL_RUN   = 8;

	logic      clk;
	logic      reset;
	fcp_beat_t in_beat;
	logic      in_valid;
	logic      in_ready;
	fcp_port_t inport_addr;
	fcp_beat_t out_beat;
	logic      out_valid;
	logic      out_ready;
	fcp_port_t outport_addr;
	fcp_en_t   wenables;
	fcp_en_t   renables;

	// Expected bytes per port in send order
	fcp_beat_t exp_q [FCP_NUM_PORTS][$];
	fcp_beat_t frame_buf [16];

	logic [31:0] data_rng;
	logic [31:0] ready_rng;
	logic        ready_random;

	string cur_test;
	int    check_count;
	int    err_count;
	int    test_errs;
	int    tests_run;
	int    tests_failed;

	fcp_switch_top u_dut (
		.clk_i          (clk),
		.reset_i        (reset),
		.in_beat_i      (in_beat),
		.in_valid_i     (in_valid),
		.in_ready_o     (in_ready),
		.inport_addr_i  (inport_addr),
		.out_beat_o     (out_beat),
		.out_valid_o    (out_valid),
		.out_ready_i    (out_ready),
		.outport_addr_i (outport_addr),
		.wenables_o     (wenables),
		.renables_o     (renables)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------
	// Helpers
	// --------------------

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Channels sit at ports 1 to 6
	function automatic logic is_mapped(input fcp_port_t port);
		return port inside {[fcp_port_t'(FCP_FIRST_CHAN) :
			fcp_port_t'(FCP_FIRST_CHAN + FCP_NUM_CHAN - 1)]};
	endfunction

	function automatic int rand_len(input int max_len);
		data_rng = xorshift(data_rng);
		return 1 + int'(data_rng % 32'(max_len));
	endfunction

	function automatic void fill_frame(input int len);
		for (int i = 0; i < len; i++)
		begin
			data_rng = xorshift(data_rng);
			frame_buf[i].data = data_rng[7:0];
			frame_buf[i].sof  = (i == 0);
			frame_buf[i].eof  = (i == len - 1);
		end
	endfunction

	// Reference model where frames to unmapped ports vanish
	function automatic void predict_frame(input fcp_port_t port, input int len);
		if (is_mapped(port))
		begin
			for (int i = 0; i < len; i++)
				exp_q[port].push_back(frame_buf[i]);
		end
	endfunction

	task automatic compare_value(input string test, input string what,
		input logic [15:0] expected, input logic [15:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			$display("FAIL %s %s: expected %h, actual %h", test, what, expected, actual);
			err_count++;
			test_errs++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout in test %s: %s", cur_test, what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs == 0)
			$display("test %s: ok", cur_test);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, test_errs);
		end
		test_errs = 0;
	endtask

	// Ends at a falling edge with in_ready high
	task automatic wait_in_ready(input string what);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!in_ready && waited < IN_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!in_ready)
			report_timeout($sformatf("in_ready_o stayed low for %0d cycles %s", IN_LIMIT, what));
	endtask

	// Wait until at most level bytes of a port are still expected
	task automatic wait_queue_level(input fcp_port_t port, input int level);
		int waited;
		waited = 0;
		while (exp_q[port].size() > level && waited < DRAIN_LIMIT)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_q[port].size() > level)
			report_timeout($sformatf("bytes on port %0d did not come out", port));
	endtask

	task automatic send_frame(input fcp_port_t port, input int len);
		fcp_en_t exp_en;
		exp_en = '0;
		if (is_mapped(port))
			exp_en = 16'd1 << port;
		fill_frame(len);
		predict_frame(port, len);
		for (int i = 0; i < len; i++)
		begin
			in_beat     = frame_buf[i];
			in_valid    = 1'b1;
			inport_addr = port;
			wait_in_ready($sformatf("while sending to port %0d", port));
			@(posedge clk);
			#1;
			// Write lock holds from sof until the whole frame is in
			compare_value(cur_test, "wenables_o while writing", exp_en, wenables);
		end
		in_valid = 1'b0;
		in_beat  = '0;
	endtask

	// Hold the drain off until the channel has stalled the input
	task automatic watch_stall();
		int waited;
		int run;
		waited = 0;
		run    = 0;
		while (run < STALL_RUN && waited < STALL_LIMIT)
		begin
			@(negedge clk);
			waited++;
			if (in_valid && !in_ready)
				run++;
			else
				run = 0;
		end
		if (run < STALL_RUN)
			report_timeout("in_ready_o never dropped while channel 4 was full");
		@(posedge clk);
		#1;
		outport_addr = 4'd4;
	endtask

	// --------------------
	// Output side
	// --------------------

	initial
	begin
		out_ready = 1'b0;
		ready_rng = SEED;
		forever
		begin
			@(posedge clk);
			#1;
			if (ready_random)
			begin
				ready_rng = xorshift(ready_rng);
				out_ready = (ready_rng[1:0] != 2'b00);
			end
			else
				out_ready = 1'b1;
		end
	end

	// Comparing process that locks onto the selected port at each sof
	initial
	begin : compare_proc
		fcp_beat_t exp_beat;
		fcp_port_t lock_port;
		logic      locked;
		locked    = 1'b0;
		lock_port = '0;
		forever
		begin
			@(negedge clk);
			if (out_valid && out_ready)
			begin
				if (out_beat.sof)
				begin
					lock_port = outport_addr;
					locked    = 1'b1;
				end
				if (!locked || !is_mapped(lock_port) || exp_q[lock_port].size() == 0)
				begin
					$display("Unexpected output beat %h on port %0d in test %s",
						out_beat, lock_port, cur_test);
					err_count++;
					test_errs++;
				end
				else
				begin
					exp_beat = exp_q[lock_port].pop_front();
					compare_value(cur_test, "data", 16'(exp_beat.data), 16'(out_beat.data));
					compare_value(cur_test, "sof", 16'(exp_beat.sof), 16'(out_beat.sof));
					compare_value(cur_test, "eof", 16'(exp_beat.eof), 16'(out_beat.eof));
				end
				if (out_beat.eof)
					locked = 1'b0;
			end
		end
	end

	// --------------------
	// Test sequence
	// --------------------

	initial
	begin : main_seq
		int c_len;
		reset        = 1'b1;
		in_beat      = '0;
		in_valid     = 1'b0;
		inport_addr  = '0;
		outport_addr = '0;
		ready_random = 1'b0;
		data_rng     = SEED;
		check_count  = 0;
		err_count    = 0;
		test_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_test     = "reset";
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test("reset");
		compare_value(cur_test, "out_valid_o", 16'd0, 16'(out_valid));
		compare_value(cur_test, "in_ready_o", 16'd0, 16'(in_ready));
		compare_value(cur_test, "wenables_o", 16'd0, wenables);
		compare_value(cur_test, "renables_o", 16'd0, renables);
		wait_in_ready("after reset");
		@(posedge clk);
		#1;
		finish_test();

		// All six channels filled first and then drained one by one
		start_test("routing");
		for (int p = FCP_FIRST_CHAN; p < FCP_FIRST_CHAN + FCP_NUM_CHAN; p++)
			send_frame(fcp_port_t'(p), rand_len(12));
		for (int p = FCP_FIRST_CHAN; p < FCP_FIRST_CHAN + FCP_NUM_CHAN; p++)
		begin
			outport_addr = fcp_port_t'(p);
			wait_queue_level(fcp_port_t'(p), 0);
		end
		finish_test();

		start_test("unmapped");
		outport_addr = 4'd3;
		send_frame(4'd0, rand_len(12));
		send_frame(4'd7, rand_len(12));
		send_frame(4'd15, rand_len(12));
		send_frame(4'd3, rand_len(12));
		wait_queue_level(4'd3, 0);
		finish_test();

		// Two frames per channel stay within one FIFO depth while nothing drains
		start_test("order");
		outport_addr = 4'd0;
		send_frame(4'd2, 8);
		send_frame(4'd5, rand_len(8));
		c_len = rand_len(8);
		send_frame(4'd2, c_len);
		send_frame(4'd5, rand_len(8));
		outport_addr = 4'd2;
		// Switch away two bytes into the first frame
		wait_queue_level(4'd2, c_len + 6);
		outport_addr = 4'd5;
		wait_queue_level(4'd5, 0);
		compare_value(cur_test, "bytes left on channel 2", 16'(c_len),
			16'(exp_q[2].size()));
		outport_addr = 4'd2;
		wait_queue_level(4'd2, 0);
		finish_test();

		// 24 bytes toward a 16 deep FIFO with no drain
		start_test("backpressure");
		outport_addr = 4'd6;
		ready_random = 1'b1;
		fork
			begin
				send_frame(4'd4, 12);
				send_frame(4'd4, 12);
			end
			watch_stall();
		join
		wait_queue_level(4'd4, 0);
		ready_random = 1'b0;
		finish_test();

		// Quiet period to catch stray output beats
		repeat (10) @(posedge clk);
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, err_count);
		if (err_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
